// ==== hdl/rs_pkg.sv ====
// Reservation station shared definitions
// Sizes, tag and payload types, and the function-unit class encoding

`default_nettype none

package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	// Eight waiting instructions
	localparam int RS_SIZE = 8;

	// Index of one entry
	localparam int RS_IDX_W = 3;

	// Occupancy count, 0 to RS_SIZE inclusive
	localparam int RS_CNT_W = 4;

	// ALU, load, store, branch
	localparam int NUM_FU = 4;

	// Physical register tag width
	localparam int TAG_W = 6;

	// Operation word handed to the function unit
	localparam int OP_W = 16;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [TAG_W-1:0] phys_tag_t;

	typedef logic [OP_W-1:0] op_word_t;

	// One bit per entry
	typedef logic [RS_SIZE-1:0] rs_mask_t;

	typedef logic [RS_CNT_W-1:0] rs_count_t;

	// Class of a dispatched instruction
	// Values double as the index of the issue ports
	typedef enum logic [1:0] {
		FU_ALU    = 2'd0,
		FU_LOAD   = 2'd1,
		FU_STORE  = 2'd2,
		FU_BRANCH = 2'd3
	} fu_class_e;

endpackage

`default_nettype wire

// ==== hdl/rs_tag_cam.sv ====
// CDB tag match for the reservation station
// Compares the broadcast tag against both source tags of every entry

`default_nettype none

module rs_tag_cam (
	input  wire logic              cdb_valid,
	input  rs_pkg::phys_tag_t      cdb_tag,
	input  rs_pkg::phys_tag_t      src1_tags [rs_pkg::RS_SIZE],
	input  rs_pkg::phys_tag_t      src2_tags [rs_pkg::RS_SIZE],
	output rs_pkg::rs_mask_t       src1_hit,
	output rs_pkg::rs_mask_t       src2_hit
);

	// All entries compared in parallel
	always_comb begin
		src1_hit = '0;
		src2_hit = '0;
		if (cdb_valid) begin
			for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
				src1_hit[i] = (src1_tags[i] == cdb_tag);
				src2_hit[i] = (src2_tags[i] == cdb_tag);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rs_pick.sv ====
// Priority selector over the entry mask
// Grants the lowest-index request, one-hot, when enabled

`default_nettype none

module rs_pick (
	input  wire logic         en,
	input  rs_pkg::rs_mask_t  req,
	output rs_pkg::rs_mask_t  gnt
);

	// Walk up from entry 0, first request wins
	always_comb begin
		logic seen;

		seen = 1'b0;
		gnt  = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			if (en && req[i] && !seen) begin
				gnt[i] = 1'b1;
			end
			seen = seen | req[i];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rs_station.sv ====
// Reservation station for a scalar out-of-order core
// Eight entries, one dispatch per cycle, CDB wakeup, and one issue
// per function-unit class each cycle. Flush empties the table.

`default_nettype none

module rs_station (
	input  wire logic                  clock,
	input  wire logic                  arst_n,
	input  wire logic                  enable,
	input  wire logic                  flush,

	// Dispatch
	input  wire logic                  dispatch_valid,
	input  rs_pkg::fu_class_e          dispatch_class,
	input  rs_pkg::phys_tag_t          dispatch_dest,
	input  rs_pkg::phys_tag_t          dispatch_src1,
	input  wire logic                  dispatch_src1_ready,
	input  rs_pkg::phys_tag_t          dispatch_src2,
	input  wire logic                  dispatch_src2_ready,
	input  rs_pkg::op_word_t           dispatch_op,

	// Common data bus
	input  wire logic                  cdb_valid,
	input  rs_pkg::phys_tag_t          cdb_tag,

	// Memory queue levels
	input  wire logic                  lq_busy,
	input  wire logic                  sq_busy,

	// Issue, indexed by class
	output logic [rs_pkg::NUM_FU-1:0]  issue_valid,
	output rs_pkg::phys_tag_t          issue_dest [rs_pkg::NUM_FU],
	output rs_pkg::op_word_t           issue_op [rs_pkg::NUM_FU],

	// Occupancy
	output logic                       rs_full,
	output rs_pkg::rs_count_t          rs_count
);

	//////////////////////////////////////////////////////////////////////
	// Entry table
	//////////////////////////////////////////////////////////////////////

	// Control state
	rs_pkg::rs_mask_t  busy;
	rs_pkg::rs_mask_t  rdy1;
	rs_pkg::rs_mask_t  rdy2;

	// Payload
	rs_pkg::fu_class_e ent_class [rs_pkg::RS_SIZE];
	rs_pkg::phys_tag_t ent_dest [rs_pkg::RS_SIZE];
	rs_pkg::phys_tag_t ent_src1 [rs_pkg::RS_SIZE];
	rs_pkg::phys_tag_t ent_src2 [rs_pkg::RS_SIZE];
	rs_pkg::op_word_t  ent_op [rs_pkg::RS_SIZE];

	// Wakeup
	rs_pkg::rs_mask_t  src1_hit;
	rs_pkg::rs_mask_t  src2_hit;
	rs_pkg::rs_mask_t  rdy1_now;
	rs_pkg::rs_mask_t  rdy2_now;

	// Issue select
	logic [rs_pkg::NUM_FU-1:0] class_en;
	rs_pkg::rs_mask_t  issue_req [rs_pkg::NUM_FU];
	rs_pkg::rs_mask_t  issue_gnt [rs_pkg::NUM_FU];
	rs_pkg::rs_mask_t  issued;

	// Dispatch select
	logic                      disp_take;
	rs_pkg::rs_mask_t          disp_gnt;
	logic [rs_pkg::RS_IDX_W-1:0] disp_idx;

	// Next state
	rs_pkg::rs_mask_t  busy_next;
	rs_pkg::rs_count_t count_next;

	//////////////////////////////////////////////////////////////////////
	// Wakeup
	//////////////////////////////////////////////////////////////////////

	rs_tag_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.src1_tags (ent_src1),
		.src2_tags (ent_src2),
		.src1_hit  (src1_hit),
		.src2_hit  (src2_hit)
	);

	// Same-cycle wakeup lets an operand issue in the cycle it is broadcast
	assign rdy1_now = rdy1 | src1_hit;
	assign rdy2_now = rdy2 | src2_hit;

	//////////////////////////////////////////////////////////////////////
	// Issue
	//////////////////////////////////////////////////////////////////////

	// Per-class issue enables
	always_comb begin
		class_en = {rs_pkg::NUM_FU{enable}};
		class_en[rs_pkg::FU_LOAD]  = enable & ~lq_busy;
		class_en[rs_pkg::FU_STORE] = enable & ~sq_busy;
	end

	// Busy, class match, both sources ready
	always_comb begin
		for (int c = 0; c < rs_pkg::NUM_FU; c++) begin
			for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
				issue_req[c][i] = busy[i] && (ent_class[i] == rs_pkg::fu_class_e'(c))
					&& rdy1_now[i] && rdy2_now[i];
			end
		end
	end

	for (genvar g = 0; g < rs_pkg::NUM_FU; g++) begin : g_issue_pick
		rs_pick u_pick (
			.en  (class_en[g]),
			.req (issue_req[g]),
			.gnt (issue_gnt[g])
		);
	end

	// Grant mux onto each class port
	always_comb begin
		issued = '0;
		for (int c = 0; c < rs_pkg::NUM_FU; c++) begin
			issue_valid[c] = |issue_gnt[c];
			issue_dest[c]  = '0;
			issue_op[c]    = '0;
			issued         = issued | issue_gnt[c];
			for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
				if (issue_gnt[c][i]) begin
					issue_dest[c] = ent_dest[i];
					issue_op[c]   = ent_op[i];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Dispatch
	//////////////////////////////////////////////////////////////////////

	assign disp_take = dispatch_valid & enable & ~rs_full;

	// Free mask taken before this cycle's issue
	rs_pick u_free_pick (
		.en  (disp_take),
		.req (~busy),
		.gnt (disp_gnt)
	);

	// One-hot to slot index for the payload write
	always_comb begin
		disp_idx = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			if (disp_gnt[i]) begin
				disp_idx = rs_pkg::RS_IDX_W'(i);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next state and occupancy
	//////////////////////////////////////////////////////////////////////

	// Issue frees, dispatch fills, flush wins over both
	always_comb begin
		if (flush) begin
			busy_next = '0;
		end else begin
			busy_next = (busy & ~issued) | disp_gnt;
		end

		count_next = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			count_next = count_next + rs_pkg::rs_count_t'(busy_next[i]);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= '0;
			rs_count <= '0;
			rs_full  <= 1'b0;
		end else begin
			busy     <= busy_next;
			rs_count <= count_next;
			rs_full  <= (count_next == rs_pkg::rs_count_t'(rs_pkg::RS_SIZE));
		end
	end

	// Ready bits keep the merged wakeup, new entries take the dispatcher's view
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rdy1 <= '0;
			rdy2 <= '0;
		end else begin
			for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
				if (disp_gnt[i]) begin
					rdy1[i] <= dispatch_src1_ready;
					rdy2[i] <= dispatch_src2_ready;
				end else begin
					rdy1[i] <= rdy1_now[i];
					rdy2[i] <= rdy2_now[i];
				end
			end
		end
	end

	// Payload write
	always_ff @(posedge clock) begin
		if (|disp_gnt) begin
			ent_class[disp_idx] <= dispatch_class;
			ent_dest[disp_idx]  <= dispatch_dest;
			ent_src1[disp_idx]  <= dispatch_src1;
			ent_src2[disp_idx]  <= dispatch_src2;
			ent_op[disp_idx]    <= dispatch_op;
		end
	end

endmodule

`default_nettype wire

// ==== include/rs_tb_vectors.svh ====
	// Per-cycle stimulus and expected responses for the reservation station
	// Rows are applied in order at one per clock cycle

`ifndef RS_TB_VECTORS_SVH
`define RS_TB_VECTORS_SVH

	// Inputs:  dispatch valid, class, dest, src1, src1_ready, src2, src2_ready, op,
	//          cdb_valid, cdb_tag, enable, lq_busy, sq_busy, flush
	// Outputs: issue_valid, dest per class, op per class (ALU, load, store, branch),
	//          rs_count after the edge that ends the cycle
	task automatic build_table();
		// Single ALU dispatch with both sources ready
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		queue_inputs(1, rs_pkg::FU_ALU, 'h05, 'h01, 1, 'h02, 1, 'h1111, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0001, 'h05, 0, 0, 0, 'h1111, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		// Wakeup on two tags after a stray and an invalid broadcast
		queue_inputs(1, rs_pkg::FU_ALU, 'h0A, 'h10, 0, 'h11, 0, 'h2222, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h12, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h10, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 'h11, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h11, 1, 0, 0, 0);
		expect_outputs(4'b0001, 'h0A, 0, 0, 0, 'h2222, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		// All four classes woken by one tag and then the second ALU entry
		queue_inputs(1, rs_pkg::FU_ALU, 'h01, 'h20, 0, 'h21, 1, 'hA001, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(1, rs_pkg::FU_LOAD, 'h02, 'h20, 0, 'h21, 1, 'hA002, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 2);
		queue_inputs(1, rs_pkg::FU_STORE, 'h03, 'h20, 0, 'h21, 1, 'hA003, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 3);
		queue_inputs(1, rs_pkg::FU_BRANCH, 'h04, 'h20, 0, 'h21, 1, 'hA004, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 4);
		queue_inputs(1, rs_pkg::FU_ALU, 'h06, 'h20, 0, 'h21, 1, 'hA006, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 5);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h20, 1, 0, 0, 0);
		expect_outputs(4'b1111, 'h01, 'h02, 'h03, 'h04, 'hA001, 'hA002, 'hA003, 'hA004, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0001, 'h06, 0, 0, 0, 'hA006, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		// Load held by lq_busy
		queue_inputs(1, rs_pkg::FU_LOAD, 'h07, 'h01, 1, 'h02, 1, 'hB001, 0, 0, 1, 1, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0010, 0, 'h07, 0, 0, 0, 'hB001, 0, 0, 0);

		// Store held by sq_busy
		queue_inputs(1, rs_pkg::FU_STORE, 'h08, 'h01, 1, 'h02, 1, 'hB002, 0, 0, 1, 0, 1, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0100, 0, 0, 'h08, 0, 0, 0, 'hB002, 0, 0);

		// enable low freezes dispatch and issue
		queue_inputs(1, rs_pkg::FU_ALU, 'h09, 'h01, 1, 'h02, 1, 'hC001, 0, 0, 0, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		queue_inputs(1, rs_pkg::FU_ALU, 'h09, 'h01, 1, 'h02, 1, 'hC001, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(1, rs_pkg::FU_BRANCH, 'h0B, 'h01, 1, 'h02, 1, 'hC002, 0, 0, 0, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0001, 'h09, 0, 0, 0, 'hC001, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		// Fill all eight entries and drop a ninth dispatch
		queue_inputs(1, rs_pkg::FU_ALU, 'h10, 'h30, 0, 'h31, 0, 'hD000, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		queue_inputs(1, rs_pkg::FU_ALU, 'h11, 'h30, 0, 'h31, 0, 'hD001, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 2);
		queue_inputs(1, rs_pkg::FU_ALU, 'h12, 'h30, 0, 'h31, 0, 'hD002, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 3);
		queue_inputs(1, rs_pkg::FU_ALU, 'h13, 'h30, 0, 'h31, 0, 'hD003, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 4);
		queue_inputs(1, rs_pkg::FU_ALU, 'h14, 'h30, 0, 'h31, 0, 'hD004, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 5);
		queue_inputs(1, rs_pkg::FU_ALU, 'h15, 'h30, 0, 'h31, 0, 'hD005, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 6);
		queue_inputs(1, rs_pkg::FU_ALU, 'h16, 'h30, 0, 'h31, 0, 'hD006, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 7);
		queue_inputs(1, rs_pkg::FU_ALU, 'h17, 'h30, 0, 'h31, 0, 'hD007, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 8);
		queue_inputs(1, rs_pkg::FU_ALU, 'h1F, 'h30, 0, 'h31, 0, 'hD0FF, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 8);

		// Flush empties the table so later wakeups find nothing
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h30, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 1, 'h31, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		// Flush wins over a dispatch in the same cycle
		queue_inputs(1, rs_pkg::FU_ALU, 'h20, 'h01, 1, 'h02, 1, 'hE001, 0, 0, 1, 0, 0, 1);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		queue_inputs(0, rs_pkg::FU_ALU, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		expect_outputs(4'b0000, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

`endif

// ==== test/rs_tb.sv ====
// Testbench for the reservation station
// Applies a per-cycle table of inputs, checks the issue ports before
// each edge and the occupancy after it

`default_nettype none

module rs_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;

	// DUT inputs for one cycle
	typedef struct packed {
		logic              valid;
		rs_pkg::fu_class_e cls;
		rs_pkg::phys_tag_t dest;
		rs_pkg::phys_tag_t src1;
		logic              src1_ready;
		rs_pkg::phys_tag_t src2;
		logic              src2_ready;
		rs_pkg::op_word_t  op;
		logic              cdb_valid;
		rs_pkg::phys_tag_t cdb_tag;
		logic              enable;
		logic              lq_busy;
		logic              sq_busy;
		logic              flush;
	} stim_t;

	// Expected outputs, count as seen after the closing edge
	typedef struct packed {
		logic [rs_pkg::NUM_FU-1:0]              valid;
		rs_pkg::phys_tag_t [rs_pkg::NUM_FU-1:0] dest;
		rs_pkg::op_word_t [rs_pkg::NUM_FU-1:0]  op;
		rs_pkg::rs_count_t                      count;
	} resp_t;

	logic                      clock;
	logic                      arst_n;
	logic                      enable;
	logic                      flush;
	logic                      dispatch_valid;
	rs_pkg::fu_class_e         dispatch_class;
	rs_pkg::phys_tag_t         dispatch_dest;
	rs_pkg::phys_tag_t         dispatch_src1;
	logic                      dispatch_src1_ready;
	rs_pkg::phys_tag_t         dispatch_src2;
	logic                      dispatch_src2_ready;
	rs_pkg::op_word_t          dispatch_op;
	logic                      cdb_valid;
	rs_pkg::phys_tag_t         cdb_tag;
	logic                      lq_busy;
	logic                      sq_busy;
	logic [rs_pkg::NUM_FU-1:0] issue_valid;
	rs_pkg::phys_tag_t         issue_dest [rs_pkg::NUM_FU];
	rs_pkg::op_word_t          issue_op [rs_pkg::NUM_FU];
	logic                      rs_full;
	rs_pkg::rs_count_t         rs_count;

	stim_t stim_q[$];
	resp_t resp_q[$];
	int    checks;
	int    errors;

	//////////////////////////////////////////////////////////////////////
	// Table building
	//////////////////////////////////////////////////////////////////////

	task automatic queue_inputs(
		input logic              valid,
		input rs_pkg::fu_class_e cls,
		input rs_pkg::phys_tag_t dest,
		input rs_pkg::phys_tag_t src1,
		input logic              src1_ready,
		input rs_pkg::phys_tag_t src2,
		input logic              src2_ready,
		input rs_pkg::op_word_t  op,
		input logic              cdb_v,
		input rs_pkg::phys_tag_t cdb_t,
		input logic              en,
		input logic              lq,
		input logic              sq,
		input logic              fl
	);
		stim_t s;

		s = {valid, cls, dest, src1, src1_ready, src2, src2_ready, op,
			cdb_v, cdb_t, en, lq, sq, fl};
		stim_q.push_back(s);
	endtask

	task automatic expect_outputs(
		input logic [rs_pkg::NUM_FU-1:0] valid,
		input rs_pkg::phys_tag_t         alu_dest,
		input rs_pkg::phys_tag_t         load_dest,
		input rs_pkg::phys_tag_t         store_dest,
		input rs_pkg::phys_tag_t         branch_dest,
		input rs_pkg::op_word_t          alu_op,
		input rs_pkg::op_word_t          load_op,
		input rs_pkg::op_word_t          store_op,
		input rs_pkg::op_word_t          branch_op,
		input rs_pkg::rs_count_t         count
	);
		resp_t r;

		r.valid                    = valid;
		r.dest[rs_pkg::FU_ALU]     = alu_dest;
		r.dest[rs_pkg::FU_LOAD]    = load_dest;
		r.dest[rs_pkg::FU_STORE]   = store_dest;
		r.dest[rs_pkg::FU_BRANCH]  = branch_dest;
		r.op[rs_pkg::FU_ALU]       = alu_op;
		r.op[rs_pkg::FU_LOAD]      = load_op;
		r.op[rs_pkg::FU_STORE]     = store_op;
		r.op[rs_pkg::FU_BRANCH]    = branch_op;
		r.count                    = count;
		resp_q.push_back(r);
	endtask

`include "rs_tb_vectors.svh"

	//////////////////////////////////////////////////////////////////////
	// DUT and clock
	//////////////////////////////////////////////////////////////////////

	rs_station dut_i (
		.clock               (clock),
		.arst_n              (arst_n),
		.enable              (enable),
		.flush               (flush),
		.dispatch_valid      (dispatch_valid),
		.dispatch_class      (dispatch_class),
		.dispatch_dest       (dispatch_dest),
		.dispatch_src1       (dispatch_src1),
		.dispatch_src1_ready (dispatch_src1_ready),
		.dispatch_src2       (dispatch_src2),
		.dispatch_src2_ready (dispatch_src2_ready),
		.dispatch_op         (dispatch_op),
		.cdb_valid           (cdb_valid),
		.cdb_tag             (cdb_tag),
		.lq_busy             (lq_busy),
		.sq_busy             (sq_busy),
		.issue_valid         (issue_valid),
		.issue_dest          (issue_dest),
		.issue_op            (issue_op),
		.rs_full             (rs_full),
		.rs_count            (rs_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Drive and check
	//////////////////////////////////////////////////////////////////////

	task automatic apply_inputs(input stim_t s);
		dispatch_valid      <= s.valid;
		dispatch_class      <= s.cls;
		dispatch_dest       <= s.dest;
		dispatch_src1       <= s.src1;
		dispatch_src1_ready <= s.src1_ready;
		dispatch_src2       <= s.src2;
		dispatch_src2_ready <= s.src2_ready;
		dispatch_op         <= s.op;
		cdb_valid           <= s.cdb_valid;
		cdb_tag             <= s.cdb_tag;
		enable              <= s.enable;
		lq_busy             <= s.lq_busy;
		sq_busy             <= s.sq_busy;
		flush               <= s.flush;
	endtask

	task automatic check_issue(input int row);
		resp_t want;

		want = resp_q[row];
		checks++;
		if (issue_valid !== want.valid) begin
			errors++;
			$display("FAILED row %0d issue_valid expected %h got %h",
				row, want.valid, issue_valid);
		end
		for (int c = 0; c < rs_pkg::NUM_FU; c++) begin
			checks++;
			if (issue_dest[c] !== want.dest[c]) begin
				errors++;
				$display("FAILED row %0d issue_dest[%0d] expected %h got %h",
					row, c, want.dest[c], issue_dest[c]);
			end
			checks++;
			if (issue_op[c] !== want.op[c]) begin
				errors++;
				$display("FAILED row %0d issue_op[%0d] expected %h got %h",
					row, c, want.op[c], issue_op[c]);
			end
		end
	endtask

	// Full whenever all entries hold an instruction
	task automatic check_count(input int row);
		rs_pkg::rs_count_t want;
		logic              want_full;

		want      = resp_q[row].count;
		want_full = (want == rs_pkg::rs_count_t'(rs_pkg::RS_SIZE));
		checks++;
		if (rs_count !== want) begin
			errors++;
			$display("FAILED row %0d rs_count expected %h got %h", row, want, rs_count);
		end
		checks++;
		if (rs_full !== want_full) begin
			errors++;
			$display("FAILED row %0d rs_full expected %h got %h", row, want_full, rs_full);
		end
	endtask

	initial begin : main
		stim_t idle;

		checks = 0;
		errors = 0;
		build_table();
		idle        = '0;
		idle.enable = 1'b1;
		arst_n      = 1'b0;
		apply_inputs(idle);
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;

		// Issue ports just before the next edge, count one cycle later
		for (int i = 0; i < stim_q.size(); i++) begin
			@(posedge clock);
			apply_inputs(stim_q[i]);
			@(negedge clock);
			if (i > 0) begin
				check_count(i - 1);
			end
			check_issue(i);
		end
		@(posedge clock);
		apply_inputs(idle);
		@(negedge clock);
		check_count(stim_q.size() - 1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Table length plus margin
	initial begin : watchdog
		#1;
		repeat (RESET_CYCLES + stim_q.size() + 20) @(posedge clock);
		$display("Timeout: the table was not finished in time");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
hdl/rs_pkg.sv
hdl/rs_tag_cam.sv
hdl/rs_pick.sv
hdl/rs_station.sv
test/rs_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
TOP        ?= rs_tb
FILE_LIST  ?= list.f
OBJ_DIR    ?= obj_dir
PASS_TEXT  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Status comes from the search for the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
